/* rtl/cachePkg.sv */
package cachePkg;

  // Cache geometry
  localparam int numSets      = 16;
  localparam int wordsPerLine = 4;
  localparam int offsetBits   = 4;
  localparam int indexBits    = 4;
  localparam int tagBits      = 24;

  // Address fields, tag | index | word | byte
  typedef logic [tagBits-1:0]   cacheTag_t;
  typedef logic [indexBits-1:0] setIndex_t;
  typedef logic [1:0]           wordSel_t;

  // Access sequencer states
  typedef enum logic [2:0] {
    ready,
    writeBack,
    fill,
    fillLast,
    uncachedRead,
    uncachedWrite,
    done
  } ctrlState_t;

endpackage

/* rtl/busPkg.sv */
package busPkg;

  // Transfer size codes on the memory bus
  localparam logic [2:0] sizeByte = 3'b000;
  localparam logic [2:0] sizeHalf = 3'b001;
  localparam logic [2:0] sizeWord = 3'b010;

  typedef logic [31:0] dataWord_t;
  typedef logic [3:0]  byteMask_t;
  typedef logic [2:0]  busSize_t;

endpackage

/* rtl/wayIf.sv */
`timescale 1ns/10ps

interface wayIf
  import cachePkg::*;
();

  // Lookup results for the addressed set
  logic      hit1;
  logic      hit2;
  logic      victimWay;
  logic      victimValid;
  logic      victimDirty;
  cacheTag_t victimTag;

  // Update requests, applied on the next edge
  logic      tagWrite;
  logic      markDirty;
  logic      touchLru;
  logic      accessWay;

  modport tagSide (
    output hit1, hit2, victimWay, victimValid, victimDirty, victimTag,
    input  tagWrite, markDirty, touchLru, accessWay
  );

  modport ctrlSide (
    input  hit1, hit2, victimWay, victimValid, victimDirty, victimTag,
    output tagWrite, markDirty, touchLru, accessWay
  );

endinterface

/* rtl/tagStore.sv */
`timescale 1ns/10ps

module tagStore
  import cachePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  setIndex_t index,
  input  cacheTag_t tag,
  wayIf.tagSide     status
);

  logic [1:0] validBits [numSets];
  logic [1:0] dirtyBits [numSets];
  // Way that was used least recently in each set
  logic       lruWay    [numSets];
  cacheTag_t  tagArray  [numSets][2];
  logic       victim;

  // Hit compare on both ways
  assign status.hit1 = validBits[index][0] & (tagArray[index][0] == tag);
  assign status.hit2 = validBits[index][1] & (tagArray[index][1] == tag);

  // Empty way first, otherwise LRU
  always_comb begin
    if (!validBits[index][0]) begin
      victim = 1'b0;
    end else if (!validBits[index][1]) begin
      victim = 1'b1;
    end else begin
      victim = lruWay[index];
    end
  end

  assign status.victimWay   = victim;
  assign status.victimValid = validBits[index][victim];
  assign status.victimDirty = dirtyBits[index][victim];
  assign status.victimTag   = tagArray[index][victim];

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int s = 0; s < numSets; s++) begin
        validBits[s]   <= 2'b00;
        dirtyBits[s]   <= 2'b00;
        lruWay[s]      <= 1'b0;
        tagArray[s][0] <= '0;
        tagArray[s][1] <= '0;
      end
    end else begin
      // Install a freshly filled line as clean
      if (status.tagWrite) begin
        tagArray[index][status.accessWay]  <= tag;
        validBits[index][status.accessWay] <= 1'b1;
        dirtyBits[index][status.accessWay] <= 1'b0;
      end
      // A store in the same cycle overrides the clean install
      if (status.markDirty) begin
        dirtyBits[index][status.accessWay] <= 1'b1;
      end
      if (status.touchLru) begin
        lruWay[index] <= ~status.accessWay;
      end
    end
  end

endmodule

/* rtl/dataStore.sv */
`timescale 1ns/10ps

module dataStore
  import cachePkg::*;
  import busPkg::*;
(
  input  logic      clk,
  input  setIndex_t index,
  input  wordSel_t  word,
  input  logic      way,
  input  logic      write,
  input  byteMask_t laneMask,
  input  dataWord_t writeWord,
  output dataWord_t readWord
);

  // Line words for both ways
  dataWord_t lineData [2][numSets][wordsPerLine];

  // Asynchronous read of the selected word
  assign readWord = lineData[way][index][word];

  // Byte lane write
  always_ff @(posedge clk) begin
    if (write) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (laneMask[lane]) begin
          lineData[way][index][word][lane*8 +: 8] <= writeWord[lane*8 +: 8];
        end
      end
    end
  end

endmodule

/* rtl/cacheController.sv */
`timescale 1ns/10ps

module cacheController
  import cachePkg::*;
  import busPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      memRead,
  input  logic      memWrite,
  input  logic      cacheable,
  input  dataWord_t addr,
  input  byteMask_t byteMask,
  wayIf.ctrlSide    status,
  input  logic      busReady,
  output logic      busRequest,
  output logic      busWrite,
  output dataWord_t busAddr,
  output busSize_t  busSize,
  output logic      stall,
  output logic      arrayWrite,
  output logic      arrayWay,
  output wordSel_t  arrayWord,
  output byteMask_t arrayMask,
  output logic      fillActive,
  output logic      uncachedData
);

  ctrlState_t state;
  ctrlState_t nextState;
  wordSel_t   beat;
  logic       missWay;
  logic       request;
  logic       hit;
  logic       hitWay;
  logic       lineBeat;
  logic       lineTransfer;
  logic       installLine;
  wordSel_t   requestWord;
  setIndex_t  index;
  busSize_t   maskSize;

  assign request      = memRead | memWrite;
  assign hit          = cacheable & (status.hit1 | status.hit2);
  assign hitWay       = status.hit2;
  assign index        = addr[offsetBits +: indexBits];
  assign requestWord  = addr[offsetBits-1:2];
  assign lineBeat     = (state == fill) | (state == fillLast);
  assign lineTransfer = lineBeat | (state == writeBack);
  // Last fill beat completes on this edge
  assign installLine  = (state == fillLast) & busReady;

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (request && !cacheable) begin
          nextState = memWrite ? uncachedWrite : uncachedRead;
        end else if (request && !hit) begin
          nextState = (status.victimValid & status.victimDirty) ? writeBack : fill;
        end
      end
      writeBack: begin
        if (busReady && beat == 2'd3) begin
          nextState = fill;
        end
      end
      fill: begin
        if (busReady && beat == 2'd2) begin
          nextState = fillLast;
        end
      end
      fillLast, uncachedRead, uncachedWrite: begin
        if (busReady) begin
          nextState = done;
        end
      end
      default: nextState = ready;
    endcase
  end

  // State, beat counter and the way being refilled
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state   <= ready;
      beat    <= '0;
      missWay <= 1'b0;
    end else begin
      state <= nextState;
      if (state == ready) begin
        beat    <= '0;
        missWay <= status.victimWay;
      end else if (lineTransfer && busReady) begin
        beat <= beat + 2'd1;
      end
    end
  end

  // Size of a single uncached beat
  always_comb begin
    case (byteMask)
      4'b1111:          maskSize = sizeWord;
      4'b0011, 4'b1100: maskSize = sizeHalf;
      default:          maskSize = sizeByte;
    endcase
  end

  always_comb begin
    case (state)
      writeBack:      busAddr = {status.victimTag, index, beat, 2'b00};
      fill, fillLast: busAddr = {addr[31:offsetBits], beat, 2'b00};
      default:        busAddr = addr;
    endcase
  end

  assign busSize    = lineTransfer ? sizeWord : maskSize;
  assign busRequest = lineTransfer | (state == uncachedRead) | (state == uncachedWrite);
  assign busWrite   = (state == writeBack) | (state == uncachedWrite);

  // Stall in ready only on a miss or bypass, done always ends the access
  assign stall = (state == ready) ? (request & ~hit) : (state != done);

  // Array side
  assign arrayWrite   = ((state == ready) & hit & memWrite) | (lineBeat & busReady);
  assign arrayWay     = (state == ready) ? hitWay : missWay;
  assign arrayWord    = lineTransfer ? beat : requestWord;
  assign arrayMask    = lineBeat ? 4'b1111 : byteMask;
  assign fillActive   = lineBeat;
  assign uncachedData = (state == uncachedRead) | (state == uncachedWrite);

  // Tag updates for hits and completed fills
  assign status.tagWrite  = installLine;
  assign status.markDirty = memWrite & (((state == ready) & hit) | installLine);
  assign status.touchLru  = ((state == ready) & request & hit) | installLine;
  assign status.accessWay = (state == ready) ? hitWay : missWay;

endmodule

/* rtl/fillMerge.sv */
`timescale 1ns/10ps

module fillMerge
  import cachePkg::*;
  import busPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      fillActive,
  input  logic      uncachedData,
  input  logic      memWrite,
  input  byteMask_t byteMask,
  input  wordSel_t  requestWord,
  input  wordSel_t  arrayWord,
  input  logic      busReady,
  input  dataWord_t busReadData,
  input  dataWord_t writeData,
  input  dataWord_t readWordIn,
  output dataWord_t arrayWriteWord,
  output dataWord_t readData,
  output dataWord_t busWriteData
);

  dataWord_t heldWord;
  logic      heldValid;
  logic      storeBeat;
  dataWord_t mergedWord;

  // Fill beat carrying the word a store missed on
  assign storeBeat = memWrite & (arrayWord == requestWord);

  always_comb begin
    for (int lane = 0; lane < 4; lane++) begin
      mergedWord[lane*8 +: 8] = (storeBeat & byteMask[lane]) ?
                                writeData[lane*8 +: 8] : busReadData[lane*8 +: 8];
    end
  end

  assign arrayWriteWord = fillActive ? mergedWord : writeData;

  // Uncached read word, valid for the done cycle only
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      heldValid <= 1'b0;
    end else begin
      heldValid <= uncachedData & busReady & ~memWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (uncachedData && busReady) begin
      heldWord <= busReadData;
    end
  end

  assign readData     = heldValid ? heldWord : readWordIn;
  assign busWriteData = uncachedData ? writeData : readWordIn;

endmodule

/* rtl/dataCache.sv */
`timescale 1ns/10ps

module dataCache
  import cachePkg::*;
  import busPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      memRead,
  input  logic      memWrite,
  input  dataWord_t addr,
  input  byteMask_t byteMask,
  input  dataWord_t writeData,
  input  logic      cacheable,
  output dataWord_t readData,
  output logic      stall,
  output logic      busRequest,
  output logic      busWrite,
  output dataWord_t busAddr,
  output dataWord_t busWriteData,
  output busSize_t  busSize,
  input  logic      busReady,
  input  dataWord_t busReadData
);

  setIndex_t index;
  cacheTag_t tag;
  wordSel_t  requestWord;
  logic      arrayWrite;
  logic      arrayWay;
  wordSel_t  arrayWord;
  byteMask_t arrayMask;
  logic      fillActive;
  logic      uncachedData;
  dataWord_t arrayWriteWord;
  dataWord_t arrayReadWord;

  // Address split into tag, set and word
  assign tag         = addr[31 -: tagBits];
  assign index       = addr[offsetBits +: indexBits];
  assign requestWord = addr[offsetBits-1:2];

  wayIf status ();

  tagStore u_tagStore (
    .clk    (clk),
    .reset  (reset),
    .index  (index),
    .tag    (tag),
    .status (status.tagSide)
  );

  dataStore u_dataStore (
    .clk       (clk),
    .index     (index),
    .word      (arrayWord),
    .way       (arrayWay),
    .write     (arrayWrite),
    .laneMask  (arrayMask),
    .writeWord (arrayWriteWord),
    .readWord  (arrayReadWord)
  );

  cacheController u_cacheController (
    .clk          (clk),
    .reset        (reset),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .cacheable    (cacheable),
    .addr         (addr),
    .byteMask     (byteMask),
    .status       (status.ctrlSide),
    .busReady     (busReady),
    .busRequest   (busRequest),
    .busWrite     (busWrite),
    .busAddr      (busAddr),
    .busSize      (busSize),
    .stall        (stall),
    .arrayWrite   (arrayWrite),
    .arrayWay     (arrayWay),
    .arrayWord    (arrayWord),
    .arrayMask    (arrayMask),
    .fillActive   (fillActive),
    .uncachedData (uncachedData)
  );

  fillMerge u_fillMerge (
    .clk            (clk),
    .reset          (reset),
    .fillActive     (fillActive),
    .uncachedData   (uncachedData),
    .memWrite       (memWrite),
    .byteMask       (byteMask),
    .requestWord    (requestWord),
    .arrayWord      (arrayWord),
    .busReady       (busReady),
    .busReadData    (busReadData),
    .writeData      (writeData),
    .readWordIn     (arrayReadWord),
    .arrayWriteWord (arrayWriteWord),
    .readData       (readData),
    .busWriteData   (busWriteData)
  );

endmodule

/* verification/memoryModel.sv */
`timescale 1ns/10ps

module memoryModel
  import busPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      busRequest,
  input  logic      busWrite,
  input  dataWord_t busAddr,
  input  dataWord_t busWriteData,
  input  busSize_t  busSize,
  output logic      busReady,
  output dataWord_t busReadData
);

  // 4 KB of words, indexed by address bits 11:2
  dataWord_t  mem [1024];
  logic [1:0] waitCount;
  logic [9:0] wordIndex;
  int         halfLane;
  int         byteLane;

  assign wordIndex   = busAddr[11:2];
  assign halfLane    = busAddr[1] * 16;
  assign byteLane    = busAddr[1:0] * 8;
  assign busReady    = busRequest & (waitCount == 2'd0);
  assign busReadData = mem[wordIndex];

  task automatic randomizeContents();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = $urandom;
    end
  endtask

  always @(posedge clk, posedge reset) begin
    if (reset) begin
      waitCount <= 2'd0;
    end else if (busRequest) begin
      if (waitCount != 2'd0) begin
        waitCount <= waitCount - 2'd1;
      end else begin
        // Beat completes here, draw the waits for the next one
        waitCount <= 2'($urandom % 4);
        if (busWrite) begin
          case (busSize)
            sizeWord: mem[wordIndex] <= busWriteData;
            sizeHalf: mem[wordIndex][halfLane +: 16] <= busWriteData[halfLane +: 16];
            default:  mem[wordIndex][byteLane +: 8] <= busWriteData[byteLane +: 8];
          endcase
        end
      end
    end
  end

endmodule

/* verification/dataCacheTb.sv */
`timescale 1ns/10ps

module dataCacheTb
  import busPkg::*;
();

  // Longest test is the random run plus a flush of every set
  localparam int cycleLimit = 6000;

  logic        clk;
  logic        reset;
  logic        memRead;
  logic        memWrite;
  dataWord_t   addr;
  byteMask_t   byteMask;
  dataWord_t   writeData;
  logic        cacheable;
  dataWord_t   readData;
  logic        stall;
  logic        busRequest;
  logic        busWrite;
  dataWord_t   busAddr;
  dataWord_t   busWriteData;
  busSize_t    busSize;
  logic        busReady;
  dataWord_t   busReadData;

  // Expected memory contents after every processor store
  dataWord_t   shadow [1024];
  int          errorCount;
  int          checkCount;
  int          cycleCount;
  int unsigned seed;

  dataCache u_dut (.*);

  memoryModel u_mem (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, an access never ended", cycleCount);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("test failed");
      $finish;
    end
  end

  task automatic checkWord(input string name, input dataWord_t actual,
                           input dataWord_t expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic checkLevel(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // Byte offset that matches the lowest active lane
  function automatic logic [1:0] laneOffset(input byteMask_t mask);
    logic [1:0] offset;
    offset = 2'd0;
    for (int lane = 3; lane >= 0; lane--) begin
      if (mask[lane]) begin
        offset = 2'(lane);
      end
    end
    return offset;
  endfunction

  // Starts and ends 2 ns after a rising edge
  task automatic access(input logic write, input logic cached, input dataWord_t address,
                        input byteMask_t mask, input dataWord_t data,
                        output dataWord_t result, output logic firstStall);
    memRead   = ~write;
    memWrite  = write;
    cacheable = cached;
    addr      = address;
    byteMask  = mask;
    writeData = data;
    @(negedge clk);
    firstStall = stall;
    while (stall) begin
      @(negedge clk);
    end
    result = readData;
    @(posedge clk);
    #2;
    memRead  = 1'b0;
    memWrite = 1'b0;
  endtask

  task automatic store(input logic cached, input dataWord_t address, input byteMask_t mask,
                       input dataWord_t data, output logic firstStall);
    dataWord_t ignored;
    for (int lane = 0; lane < 4; lane++) begin
      if (mask[lane]) begin
        shadow[address[11:2]][lane*8 +: 8] = data[lane*8 +: 8];
      end
    end
    access(1'b1, cached, address, mask, data, ignored, firstStall);
  endtask

  task automatic load(input logic cached, input dataWord_t address, output logic firstStall);
    dataWord_t result;
    access(1'b0, cached, address, 4'b1111, '0, result, firstStall);
    checkWord("readData", result, shadow[address[11:2]]);
  endtask

  // Two unused tags per set push every resident line out
  task automatic flushLines(input dataWord_t base);
    logic firstStall;
    for (int s = 0; s < 16; s++) begin
      load(1'b1, base + s * 16, firstStall);
      load(1'b1, base + 256 + s * 16, firstStall);
    end
  endtask

  task automatic compareMemory();
    for (int i = 0; i < 1024; i++) begin
      checkWord($sformatf("mem[%0d]", i), u_mem.mem[i], shadow[i]);
    end
  endtask

  task automatic testReset();
    logic firstStall;
    @(negedge clk);
    checkLevel("stall", stall, 1'b0);
    checkLevel("busRequest", busRequest, 1'b0);
    checkLevel("busWrite", busWrite, 1'b0);
    @(posedge clk);
    #2;
    load(1'b1, 32'h0000_0044, firstStall);
    checkLevel("stall", firstStall, 1'b1);
  endtask

  task automatic testLineFill();
    logic firstStall;
    load(1'b1, 32'h0000_0084, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    for (int w = 0; w < 4; w++) begin
      load(1'b1, 32'h0000_0080 + w * 4, firstStall);
      checkLevel("stall", firstStall, 1'b0);
    end
  endtask

  task automatic testStores();
    logic firstStall;
    store(1'b1, 32'h0000_0081, 4'b0010, $urandom, firstStall);
    checkLevel("stall", firstStall, 1'b0);
    store(1'b1, 32'h0000_008E, 4'b1100, $urandom, firstStall);
    checkLevel("stall", firstStall, 1'b0);
    store(1'b1, 32'h0000_0088, 4'b1111, $urandom, firstStall);
    for (int w = 0; w < 4; w++) begin
      load(1'b1, 32'h0000_0080 + w * 4, firstStall);
    end
    // Store misses merge into the fill
    store(1'b1, 32'h0000_00C7, 4'b1000, $urandom, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    store(1'b1, 32'h0000_00D2, 4'b1100, $urandom, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    load(1'b1, 32'h0000_00C4, firstStall);
    load(1'b1, 32'h0000_00C0, firstStall);
    load(1'b1, 32'h0000_00D0, firstStall);
  endtask

  task automatic testEviction();
    logic firstStall;
    store(1'b1, 32'h0000_0050, 4'b1111, $urandom, firstStall);
    load(1'b1, 32'h0000_0150, firstStall);
    load(1'b1, 32'h0000_0050, firstStall);
    checkLevel("stall", firstStall, 1'b0);
    // Third tag replaces 0x150, the older way
    load(1'b1, 32'h0000_0250, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    load(1'b1, 32'h0000_0050, firstStall);
    checkLevel("stall", firstStall, 1'b0);
    load(1'b1, 32'h0000_0150, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    flushLines(32'h0000_0600);
    compareMemory();
  endtask

  task automatic testUncached();
    logic firstStall;
    store(1'b0, 32'h0000_0804, 4'b1111, $urandom, firstStall);
    checkLevel("stall", firstStall, 1'b1);
    checkWord("mem[513]", u_mem.mem[513], shadow[513]);
    load(1'b0, 32'h0000_0804, firstStall);
    store(1'b0, 32'h0000_0809, 4'b0010, $urandom, firstStall);
    checkWord("mem[514]", u_mem.mem[514], shadow[514]);
    checkWord("mem[515]", u_mem.mem[515], shadow[515]);
    load(1'b0, 32'h0000_0808, firstStall);
    // Same set index, tag store must not change
    load(1'b1, 32'h0000_0030, firstStall);
    load(1'b0, 32'h0000_0830, firstStall);
    store(1'b0, 32'h0000_0936, 4'b1100, $urandom, firstStall);
    load(1'b1, 32'h0000_0030, firstStall);
    checkLevel("stall", firstStall, 1'b0);
    load(1'b1, 32'h0000_0330, firstStall);
    checkLevel("stall", firstStall, 1'b1);
  endtask

  task automatic testRandom();
    logic      firstStall;
    logic      cached;
    logic      write;
    byteMask_t mask;
    dataWord_t address;
    byteMask_t masks [7];
    masks = '{4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
    for (int n = 0; n < 200; n++) begin
      cached = ($urandom % 2) == 1;
      write  = ($urandom % 2) == 1;
      mask   = masks[$urandom % 7];
      // Cached lines below 0x400, uncached words from 0x800
      if (cached) begin
        address = ($urandom % 256) * 4;
      end else begin
        address = 32'h0000_0800 + ($urandom % 64) * 4;
      end
      address[1:0] = laneOffset(mask);
      if (write) begin
        store(cached, address, mask, $urandom, firstStall);
      end else begin
        load(cached, address, firstStall);
      end
    end
    flushLines(32'h0000_0400);
    compareMemory();
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    addr       = '0;
    byteMask   = '0;
    writeData  = '0;
    cacheable  = 1'b0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    seed       = 32'h2872_2929;
    void'($urandom(seed));
    u_mem.randomizeContents();
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = u_mem.mem[i];
    end
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    testReset();
    testLineFill();
    testStores();
    testEviction();
    testUncached();
    testRandom();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* dataCache.f */
rtl/cachePkg.sv
rtl/busPkg.sv
rtl/wayIf.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/cacheController.sv
rtl/fillMerge.sv
rtl/dataCache.sv
verification/memoryModel.sv
verification/dataCacheTb.sv

/* Bender.yml */
package:
  name: dataCache

sources:
  - rtl/cachePkg.sv
  - rtl/busPkg.sv
  - rtl/wayIf.sv
  - rtl/tagStore.sv
  - rtl/dataStore.sv
  - rtl/cacheController.sv
  - rtl/fillMerge.sv
  - rtl/dataCache.sv
  - target: test
    files:
      - verification/memoryModel.sv
      - verification/dataCacheTb.sv
